// ==== dv/m_csr_unit_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module m_csr_unit_properties
    import csr_addr_pkg::*;
(
    input wire       clk,
    input wire       rst_n,
    input wire       illegal,
    input wire [4:0] wr_sel,
    input wire       trap_valid,
    input wire       mret,
    input wire       redirect_valid,
    input wire [1:0] priv_mode
);

    // An illegal access must never reach a register
    assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> (wr_sel == 5'b0))
        else $error("illegal access produced a write select");

    // Fetch is redirected exactly when a trap or an mret is present
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid == (trap_valid | mret))
        else $error("redirect_valid differs from trap or mret");

    // Trap entry always lands in machine mode
    assert property (@(posedge clk) disable iff (!rst_n)
        trap_valid |=> (priv_mode == priv_machine))
        else $error("privilege mode is not machine after a trap");

endmodule : m_csr_unit_properties

bind m_csr_unit m_csr_unit_properties u_properties (
    .clk            (clk),
    .rst_n          (rst_n),
    .illegal        (illegal),
    .wr_sel         (wr_cmd.sel),
    .trap_valid     (trap_req.valid),
    .mret           (mret),
    .redirect_valid (redirect_valid),
    .priv_mode      (priv_mode)
);

`default_nettype wire

// ==== dv/m_csr_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module m_csr_unit_tb
    import csr_addr_pkg::*;
    import csr_op_pkg::*;
();

    logic        clk;
    logic        rst_n;
    csr_req_t    csr_req;
    trap_req_t   trap_req;
    logic        mret;
    logic [31:0] csr_rdata;
    logic        illegal;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    priv_mode_e  priv_mode;
    logic        irq_enable;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lcg_state;

    // Expected architectural state
    logic        m_mie;
    logic        m_mpie;
    logic [1:0]  m_mpp;
    logic [1:0]  m_mode;
    logic [31:0] mtvec_val;
    logic [31:0] scratch_val;

    m_csr_unit #(
        .mtvec_reset (32'h0000_0100)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_req        (csr_req),
        .trap_req       (trap_req),
        .mret           (mret),
        .csr_rdata      (csr_rdata),
        .illegal        (illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .priv_mode      (priv_mode),
        .irq_enable     (irq_enable)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Run limit well above the length of all tests
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 400) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected mstatus with only the live fields
    function automatic logic [31:0] mstatus_exp();
        logic [31:0] v;
        v = 32'h0;
        v[mstatus_mie] = m_mie;
        v[mstatus_mpie] = m_mpie;
        v[mstatus_mpp_hi:mstatus_mpp_lo] = m_mpp;
        return v;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic idle();
        csr_req = '0;
        trap_req = '0;
        mret = 1'b0;
    endtask

    // One CSR request sampled mid-cycle with inputs released after the edge
    task automatic access(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic ill);
        csr_req.valid = 1'b1;
        csr_req.op = op;
        csr_req.addr = addr;
        csr_req.wdata = wdata;
        @(negedge clk);
        rdata = csr_rdata;
        ill = illegal;
        @(posedge clk);
        #1;
        idle();
    endtask

    // Set with zero mask reads without changing anything
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] rdata);
        logic ill;
        access(csr_rs, addr, 32'h0, rdata, ill);
    endtask

    task automatic write_mstatus(input logic [31:0] d);
        logic [31:0] r;
        logic        ill;
        access(csr_rw, csr_mstatus, d, r, ill);
        m_mie = d[3];
        m_mpie = d[7];
        // S mode and reserved encodings leave MPP alone
        if (d[12:11] == 2'b00 || d[12:11] == 2'b11) begin
            m_mpp = d[12:11];
        end
        read_csr(csr_mstatus, r);
        check(r, mstatus_exp(), "mstatus readback");
        check(irq_enable, m_mie, "irq_enable follows MIE");
    endtask

    // Trap with redirect check followed by the captured state
    task automatic take_trap(input logic [31:0] cause, input logic [31:0] pc);
        logic [31:0] r;
        trap_req.valid = 1'b1;
        trap_req.cause = cause;
        trap_req.pc = pc;
        @(negedge clk);
        check(redirect_valid, 1'b1, "redirect_valid on trap");
        check(redirect_pc, mtvec_val, "redirect_pc on trap");
        check(illegal, 1'b0, "illegal during trap");
        @(posedge clk);
        #1;
        idle();
        m_mpie = m_mie;
        m_mie = 1'b0;
        m_mpp = m_mode;
        m_mode = priv_machine;
        check(priv_mode, m_mode, "mode after trap");
        read_csr(csr_mepc, r);
        check(r, {pc[31:2], 2'b00}, "mepc after trap");
        read_csr(csr_mcause, r);
        check(r, cause, "mcause after trap");
        read_csr(csr_mstatus, r);
        check(r, mstatus_exp(), "mstatus after trap");
    endtask

    task automatic reset_values();
        logic [31:0] r;
        check(priv_mode, priv_machine, "mode at reset");
        check(irq_enable, 1'b0, "irq_enable at reset");
        read_csr(csr_mstatus, r);
        check(r, 32'h0000_1800, "mstatus at reset");
        read_csr(csr_mtvec, r);
        check(r, 32'h0000_0100, "mtvec at reset");
        read_csr(csr_mepc, r);
        check(r, 32'h0, "mepc at reset");
        read_csr(csr_mcause, r);
        check(r, 32'h0, "mcause at reset");
        read_csr(csr_mscratch, r);
        check(r, 32'h0, "mscratch at reset");
        $display("reset values done, errors so far %0d", errors);
    endtask

    task automatic csr_ops();
        logic [31:0] r;
        logic [31:0] d;
        logic        ill;
        // Each access reads the result of the one before
        d = next_rand();
        access(csr_rw, csr_mscratch, d, r, ill);
        check(r, scratch_val, "mscratch before rw");
        scratch_val = d;
        d = next_rand();
        access(csr_rs, csr_mscratch, d, r, ill);
        check(r, scratch_val, "mscratch before rs");
        scratch_val = scratch_val | d;
        d = next_rand();
        access(csr_rc, csr_mscratch, d, r, ill);
        check(r, scratch_val, "mscratch before rc");
        scratch_val = scratch_val & ~d;
        read_csr(csr_mscratch, r);
        check(r, scratch_val, "mscratch after rc");
        d = next_rand();
        access(csr_rw, csr_mepc, d, r, ill);
        read_csr(csr_mepc, r);
        check(r, {d[31:2], 2'b00}, "mepc write mask");
        d = next_rand();
        access(csr_rw, csr_mtvec, d, r, ill);
        mtvec_val = {d[31:2], 2'b00};
        read_csr(csr_mtvec, r);
        check(r, mtvec_val, "mtvec write mask");
        $display("csr ops done, errors so far %0d", errors);
    endtask

    task automatic mstatus_fields();
        write_mstatus(next_rand());
        // MPP 01 with MIE set, then MPP 10 with MPIE set
        write_mstatus(32'h0000_0808);
        write_mstatus(32'h0000_1080);
        $display("mstatus fields done, errors so far %0d", errors);
    endtask

    task automatic trap_entry();
        write_mstatus(32'h0000_1888);
        take_trap(32'h0000_000b, next_rand());
        $display("trap entry done, errors so far %0d", errors);
    endtask

    task automatic mret_to_user();
        logic [31:0] r;
        logic [31:0] d;
        logic        ill;
        d = next_rand();
        access(csr_rw, csr_mepc, d, r, ill);
        // Return to user with MPIE set
        write_mstatus(32'h0000_0080);
        mret = 1'b1;
        @(negedge clk);
        check(redirect_valid, 1'b1, "redirect_valid on mret");
        check(redirect_pc, {d[31:2], 2'b00}, "redirect_pc on mret");
        @(posedge clk);
        #1;
        idle();
        m_mode = m_mpp;
        m_mie = m_mpie;
        m_mpie = 1'b1;
        m_mpp = priv_user;
        check(priv_mode, m_mode, "mode after mret");
        check(irq_enable, m_mie, "MIE after mret");
        // User mode may touch no CSR
        access(csr_rw, csr_mscratch, next_rand(), r, ill);
        check(ill, 1'b1, "illegal on mscratch in user mode");
        access(csr_rw, csr_mtvec, next_rand(), r, ill);
        check(ill, 1'b1, "illegal on mtvec in user mode");
        // A user request under the trap must not raise illegal
        csr_req.valid = 1'b1;
        csr_req.op = csr_rw;
        csr_req.addr = csr_mscratch;
        csr_req.wdata = next_rand();
        take_trap(32'h0000_0008, next_rand());
        read_csr(csr_mscratch, r);
        check(r, scratch_val, "mscratch unchanged by user access");
        $display("mret to user done, errors so far %0d", errors);
    endtask

    task automatic priority_and_unknown();
        logic [31:0] r;
        logic        ill;
        // CSR write sharing its cycle with a trap
        csr_req.valid = 1'b1;
        csr_req.op = csr_rw;
        csr_req.addr = csr_mscratch;
        csr_req.wdata = next_rand();
        take_trap(32'h8000_0003, next_rand());
        read_csr(csr_mscratch, r);
        check(r, scratch_val, "write dropped under trap");
        access(csr_rw, 12'h7c0, next_rand(), r, ill);
        check(ill, 1'b1, "illegal on unknown address");
        check(r, 32'h0, "unknown address reads zero");
        $display("priority and unknown address done, errors so far %0d", errors);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        lcg_state = 32'hd805_37ae;
        idle();
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_mpp = priv_machine;
        m_mode = priv_machine;
        mtvec_val = 32'h0000_0100;
        scratch_val = 32'h0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        csr_ops();
        mstatus_fields();
        trap_entry();
        mret_to_user();
        priority_and_unknown();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : m_csr_unit_tb

`default_nettype wire

// ==== m_csr_unit.f ====
src/csr_addr_pkg.sv
src/csr_op_pkg.sv
src/csr_cmd_decode.sv
src/mstatus_reg.sv
src/trap_csr_file.sv
src/csr_read_mux.sv
src/m_csr_unit.sv
dv/m_csr_unit_properties.sv
dv/m_csr_unit_tb.sv

// ==== src/csr_addr_pkg.sv ====
`default_nettype none

package csr_addr_pkg;

    // Only M and U modes exist in this core
    // The encodings follow the MPP field of mstatus
    typedef enum logic [1:0] {
        priv_user    = 2'b00,
        priv_machine = 2'b11
    } priv_mode_e;

    // Machine-mode CSR addresses handled by the unit
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;

    // Bit positions of the live mstatus fields
    // Every other mstatus bit is hardwired to zero
    // Machine interrupt enable
    localparam int mstatus_mie    = 3;

    // Machine previous interrupt enable
    localparam int mstatus_mpie   = 7;

    // Machine previous privilege is two bits wide
    localparam int mstatus_mpp_lo = 11;
    localparam int mstatus_mpp_hi = 12;

endpackage : csr_addr_pkg

`default_nettype wire

// ==== src/csr_cmd_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_cmd_decode
    import csr_addr_pkg::*;
    import csr_op_pkg::*;
(
    input  csr_req_t   csr_req,
    input  priv_mode_e priv_mode,
    input  wire [31:0] old_data,
    input  wire        trap_valid,
    input  wire        mret,
    output csr_wr_t    wr_cmd,
    output logic       illegal
);

    logic [4:0]  addr_sel;
    logic        addr_known;
    logic        cycle_taken;
    logic [31:0] new_data;

    // Map the address onto its one-hot select
    always_comb begin
        addr_sel = '0;
        case (csr_req.addr)
            csr_mstatus:  addr_sel[sel_mstatus]  = 1'b1;
            csr_mtvec:    addr_sel[sel_mtvec]    = 1'b1;
            csr_mscratch: addr_sel[sel_mscratch] = 1'b1;
            csr_mepc:     addr_sel[sel_mepc]     = 1'b1;
            csr_mcause:   addr_sel[sel_mcause]   = 1'b1;
            default:      addr_sel = '0;
        endcase
    end

    assign addr_known = |addr_sel;

    // Trap beats mret beats CSR write
    // A request sharing its cycle with either is silently dropped
    assign cycle_taken = trap_valid | mret;

    // All CSRs here are machine level, so user mode may touch none of them
    assign illegal = csr_req.valid & ~cycle_taken &
                     ((priv_mode == priv_user) | ~addr_known);

    // Read-modify-write value from the current register contents
    always_comb begin
        case (csr_req.op)
            csr_rw:  new_data = csr_req.wdata;
            csr_rs:  new_data = old_data | csr_req.wdata;
            csr_rc:  new_data = old_data & ~csr_req.wdata;
            // Unused encoding keeps the old value
            default: new_data = old_data;
        endcase
    end

    // Unknown addresses already give an empty select
    assign wr_cmd.sel  = (csr_req.valid & ~cycle_taken & (priv_mode != priv_user)) ?
                         addr_sel : 5'b0;
    assign wr_cmd.data = new_data;

endmodule : csr_cmd_decode

`default_nettype wire

// ==== src/csr_op_pkg.sv ====
`default_nettype none

package csr_op_pkg;

    // CSR instruction kind from the low two bits of funct3
    typedef enum logic [1:0] {
        csr_rw = 2'b01,
        csr_rs = 2'b10,
        csr_rc = 2'b11
    } csr_op_e;

    // Single-cycle CSR access strobe from the pipeline
    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

    // Trap request raised from outside the unit
    typedef struct packed {
        logic        valid;
        logic [31:0] cause;
        logic [31:0] pc;
    } trap_req_t;

    // Write command with one select bit per CSR
    typedef struct packed {
        logic [4:0]  sel;
        logic [31:0] data;
    } csr_wr_t;

    // Select bit positions from mstatus at the MSB down to mcause
    localparam int sel_mstatus  = 4;
    localparam int sel_mtvec    = 3;
    localparam int sel_mscratch = 2;
    localparam int sel_mepc     = 1;
    localparam int sel_mcause   = 0;

endpackage : csr_op_pkg

`default_nettype wire

// ==== src/csr_read_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux
    import csr_addr_pkg::*;
(
    input  wire  [11:0] addr,
    input  wire  [31:0] mstatus,
    input  wire  [31:0] mtvec,
    input  wire  [31:0] mepc,
    input  wire  [31:0] mcause,
    input  wire  [31:0] mscratch,
    input  wire         trap_valid,
    input  wire         mret,
    output logic [31:0] rdata,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    // Read data is the registered value, so a write shows next cycle
    always_comb begin
        case (addr)
            csr_mstatus:  rdata = mstatus;
            csr_mtvec:    rdata = mtvec;
            csr_mscratch: rdata = mscratch;
            csr_mepc:     rdata = mepc;
            csr_mcause:   rdata = mcause;
            // Unimplemented address reads as zero
            default:      rdata = '0;
        endcase
    end

    // Fetch redirect
    // Trap goes to the handler base, mret back to the saved pc
    assign redirect_valid = trap_valid | mret;
    assign redirect_pc    = trap_valid ? mtvec : mepc;

endmodule : csr_read_mux

`default_nettype wire

// ==== src/m_csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module m_csr_unit
    import csr_addr_pkg::*;
    import csr_op_pkg::*;
#(
    parameter logic [31:0] mtvec_reset = 32'h0000_0100
) (
    input  wire         clk,
    input  wire         rst_n,
    input  csr_req_t    csr_req,
    input  trap_req_t   trap_req,
    input  wire         mret,
    output logic [31:0] csr_rdata,
    output logic        illegal,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output priv_mode_e  priv_mode,
    output logic        irq_enable
);

    // Write command from the decoder
    csr_wr_t     wr_cmd;

    // Current CSR contents
    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mscratch;

    // Legality check and read-modify-write value
    // Old data is the addressed register, fed back from the read mux
    csr_cmd_decode u_decode (
        .csr_req    (csr_req),
        .priv_mode  (priv_mode),
        .old_data   (csr_rdata),
        .trap_valid (trap_req.valid),
        .mret       (mret),
        .wr_cmd     (wr_cmd),
        .illegal    (illegal)
    );

    mstatus_reg u_mstatus (
        .clk        (clk),
        .rst_n      (rst_n),
        .trap_valid (trap_req.valid),
        .mret       (mret),
        .wr_en      (wr_cmd.sel[sel_mstatus]),
        .wr_data    (wr_cmd.data),
        .mstatus    (mstatus),
        .priv_mode  (priv_mode),
        .irq_enable (irq_enable)
    );

    trap_csr_file #(
        .mtvec_reset (mtvec_reset)
    ) u_trap_csrs (
        .clk      (clk),
        .rst_n    (rst_n),
        .trap     (trap_req),
        .wr_cmd   (wr_cmd),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .mscratch (mscratch)
    );

    csr_read_mux u_read_mux (
        .addr           (csr_req.addr),
        .mstatus        (mstatus),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .mcause         (mcause),
        .mscratch       (mscratch),
        .trap_valid     (trap_req.valid),
        .mret           (mret),
        .rdata          (csr_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule : m_csr_unit

`default_nettype wire

// ==== src/mstatus_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module mstatus_reg
    import csr_addr_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         trap_valid,
    input  wire         mret,
    input  wire         wr_en,
    input  wire  [31:0] wr_data,
    output logic [31:0] mstatus,
    output priv_mode_e  priv_mode,
    output logic        irq_enable
);

    // Current privilege mode of the hart
    priv_mode_e mode_q;

    // Live mstatus fields
    logic       mie_q;
    logic       mpie_q;
    priv_mode_e mpp_q;

    // MPP field of an incoming CSR write
    logic [1:0] wr_mpp;
    logic       wr_mpp_ok;

    assign wr_mpp = wr_data[mstatus_mpp_hi:mstatus_mpp_lo];

    // Only U and M are legal, S and reserved encodings are ignored
    assign wr_mpp_ok = (wr_mpp == priv_user) | (wr_mpp == priv_machine);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Come out of reset in machine mode with interrupts off
            mode_q <= priv_machine;
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
            mpp_q  <= priv_machine;
        end else if (trap_valid) begin
            // Trap entry stacks the enable and the mode
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
            mpp_q  <= mode_q;
            mode_q <= priv_machine;
        end else if (mret) begin
            // Unstack, then leave MPP at the least privileged mode
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
            mode_q <= mpp_q;
            mpp_q  <= priv_user;
        end else if (wr_en) begin
            mie_q  <= wr_data[mstatus_mie];
            mpie_q <= wr_data[mstatus_mpie];
            if (wr_mpp_ok) begin
                mpp_q <= priv_mode_e'(wr_mpp);
            end
        end
    end

    // SIE, UIE, SPIE, UPIE, SPP, MPRV, MXR, SUM, TVM, TW, TSR, FS, XS and SD
    // all stay zero
    always_comb begin
        mstatus = '0;
        mstatus[mstatus_mie]  = mie_q;
        mstatus[mstatus_mpie] = mpie_q;
        mstatus[mstatus_mpp_hi:mstatus_mpp_lo] = mpp_q;
    end

    assign priv_mode  = mode_q;
    assign irq_enable = mie_q;

endmodule : mstatus_reg

`default_nettype wire

// ==== src/trap_csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module trap_csr_file
    import csr_op_pkg::*;
#(
    parameter logic [31:0] mtvec_reset = 32'h0000_0100
) (
    input  wire         clk,
    input  wire         rst_n,
    input  trap_req_t   trap,
    input  csr_wr_t     wr_cmd,
    output logic [31:0] mtvec,
    output logic [31:0] mepc,
    output logic [31:0] mcause,
    output logic [31:0] mscratch
);

    // Write data with the low two bits forced to zero
    // Used by mtvec (direct mode only) and mepc (IALIGN 32)
    logic [31:0] wr_aligned;

    assign wr_aligned = {wr_cmd.data[31:2], 2'b00};

    // Trap base address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec <= mtvec_reset;
        end else if (wr_cmd.sel[sel_mtvec]) begin
            mtvec <= wr_aligned;
        end
    end

    // Scratch register is plain storage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (wr_cmd.sel[sel_mscratch]) begin
            mscratch <= wr_cmd.data;
        end
    end

    // Exception pc and cause
    // Trap capture wins over a CSR write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (trap.valid) begin
            mepc   <= {trap.pc[31:2], 2'b00};
            mcause <= trap.cause;
        end else begin
            if (wr_cmd.sel[sel_mepc]) begin
                mepc <= wr_aligned;
            end
            // No WARL filtering on cause codes
            if (wr_cmd.sel[sel_mcause]) begin
                mcause <= wr_cmd.data;
            end
        end
    end

endmodule : trap_csr_file

`default_nettype wire
